/* verilog/ooo_consts.svh */
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// issue queue depth, power of two and at most 8 for the 4-bit wrapping tag
`define OOO_IQ_SIZE 8

// alu lanes, one writeback bank each
`define OOO_NUM_LANES 2

`define OOO_PHYS_REGS 32
`define OOO_PREG_W 5
`define OOO_TAG_W 4
`define OOO_XLEN 32

`endif

/* verilog/ooo_pkg.sv */
`include "ooo_consts.svh"

package ooo_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT
  } alu_cmd_t;

  // renamed instruction from the front end, imm replaces src2 when use_imm
  typedef struct packed {
    alu_cmd_t                alu_cmd;
    logic [`OOO_PREG_W-1:0]  src1;
    logic [`OOO_PREG_W-1:0]  src2;
    logic                    use_imm;
    logic [`OOO_XLEN-1:0]    imm;
    logic [`OOO_PREG_W-1:0]  phys_rd;
  } dispatch_req_t;

  // operand data holds the source register number until the operand is valid
  typedef struct packed {
    alu_cmd_t                alu_cmd;
    logic [`OOO_XLEN-1:0]    op1_data;
    logic [`OOO_XLEN-1:0]    op2_data;
    logic                    op1_valid;
    logic                    op2_valid;
    logic [`OOO_PREG_W-1:0]  phys_rd;
  } iq_entry_t;

  typedef struct packed {
    alu_cmd_t                alu_cmd;
    logic [`OOO_XLEN-1:0]    op1;
    logic [`OOO_XLEN-1:0]    op2;
    logic [`OOO_PREG_W-1:0]  phys_rd;
  } exec_op_t;

  typedef struct packed {
    logic                    valid;
    logic [`OOO_PREG_W-1:0]  phys_rd;
    logic [`OOO_XLEN-1:0]    data;
  } wb_bank_t;

  typedef wb_bank_t [`OOO_NUM_LANES-1:0] wb_bus_t;

endpackage

/* verilog/phys_regfile.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module phys_regfile (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`OOO_PREG_W-1:0] rd_addr_a,
  input  logic [`OOO_PREG_W-1:0] rd_addr_b,
  output logic [`OOO_XLEN-1:0]   rd_data_a,
  output logic [`OOO_XLEN-1:0]   rd_data_b,
  output logic                   rd_ready_a,
  output logic                   rd_ready_b,
  input  logic                   alloc_valid,
  input  logic [`OOO_PREG_W-1:0] alloc_rd,
  input  ooo_pkg::wb_bus_t       wb_bus
);

  logic [`OOO_XLEN-1:0]      regs [`OOO_PHYS_REGS];
  logic [`OOO_PHYS_REGS-1:0] ready;

  // register 0 is hardwired to zero and always ready
  always_comb begin
    rd_data_a  = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    rd_data_b  = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];
    rd_ready_a = ready[rd_addr_a];
    rd_ready_b = ready[rd_addr_b];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
      ready <= '1;
    end else begin
      for (int b = 0; b < `OOO_NUM_LANES; b++) begin
        if (wb_bus[b].valid && wb_bus[b].phys_rd != '0) begin
          regs[wb_bus[b].phys_rd]  <= wb_bus[b].data;
          ready[wb_bus[b].phys_rd] <= 1'b1;
        end
      end
      // new destination waits for its producer
      if (alloc_valid && alloc_rd != '0) begin
        ready[alloc_rd] <= 1'b0;
      end
    end
  end

endmodule

/* verilog/dispatch_unit.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module dispatch_unit (
  input  logic                    dispatch_valid,
  input  ooo_pkg::dispatch_req_t  dispatch_req,
  input  logic                    full,
  output logic [`OOO_PREG_W-1:0]  rd_addr_a,
  output logic [`OOO_PREG_W-1:0]  rd_addr_b,
  input  logic [`OOO_XLEN-1:0]    rd_data_a,
  input  logic [`OOO_XLEN-1:0]    rd_data_b,
  input  logic                    rd_ready_a,
  input  logic                    rd_ready_b,
  input  ooo_pkg::wb_bus_t        wb_bus,
  output ooo_pkg::iq_entry_t      entry,
  output logic                    entry_write,
  output logic                    alloc_valid,
  output logic [`OOO_PREG_W-1:0]  alloc_rd
);

  logic [`OOO_XLEN:0] opnd1;
  logic [`OOO_XLEN:0] opnd2;

  // returns {valid, data}; a pending operand keeps its register number as data
  function automatic logic [`OOO_XLEN:0] resolve(
    input logic [`OOO_PREG_W-1:0] src,
    input logic [`OOO_XLEN-1:0]   rf_data,
    input logic                   rf_ready,
    input ooo_pkg::wb_bus_t       bus
  );
    logic [`OOO_XLEN:0] res;
    res = {1'b0, `OOO_XLEN'(src)};
    if (rf_ready) begin
      res = {1'b1, rf_data};
    end
    // bypass the result being written back this cycle
    for (int b = 0; b < `OOO_NUM_LANES; b++) begin
      if (bus[b].valid && bus[b].phys_rd == src && src != '0) begin
        res = {1'b1, bus[b].data};
      end
    end
    return res;
  endfunction

  assign rd_addr_a = dispatch_req.src1;
  assign rd_addr_b = dispatch_req.src2;

  always_comb begin
    opnd1 = resolve(dispatch_req.src1, rd_data_a, rd_ready_a, wb_bus);
    if (dispatch_req.use_imm) begin
      opnd2 = {1'b1, dispatch_req.imm};
    end else begin
      opnd2 = resolve(dispatch_req.src2, rd_data_b, rd_ready_b, wb_bus);
    end

    entry.alu_cmd   = dispatch_req.alu_cmd;
    entry.op1_valid = opnd1[`OOO_XLEN];
    entry.op1_data  = opnd1[`OOO_XLEN-1:0];
    entry.op2_valid = opnd2[`OOO_XLEN];
    entry.op2_data  = opnd2[`OOO_XLEN-1:0];
    entry.phys_rd   = dispatch_req.phys_rd;
  end

  // accepted only while the queue has a free slot
  assign entry_write = dispatch_valid && !full;
  assign alloc_valid = entry_write && (dispatch_req.phys_rd != '0);
  assign alloc_rd    = dispatch_req.phys_rd;

endmodule

/* verilog/issue_queue.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module issue_queue (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       entry_write,
  input  ooo_pkg::iq_entry_t         entry,
  output logic                       full,
  input  ooo_pkg::wb_bus_t           wb_bus,
  output logic [`OOO_NUM_LANES-1:0]  lane_valid,
  output ooo_pkg::exec_op_t          issue_op
);

  localparam int N      = `OOO_IQ_SIZE;
  localparam int IDX_W  = $clog2(N);
  localparam int TAG_W  = `OOO_TAG_W;
  localparam int LANES  = `OOO_NUM_LANES;
  localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;

  ooo_pkg::iq_entry_t slots    [N];
  logic [TAG_W-1:0]   slot_tag [N];
  logic [N-1:0]       slot_valid;
  logic [TAG_W-1:0]   tag_ctr;
  logic [LANE_W-1:0]  rr_lane;

  // both trees in heap order: root at 1, leaves at N..2N-1
  logic               sel_rdy  [1:2*N-1];
  logic [IDX_W-1:0]   sel_idx  [1:2*N-1];
  logic [TAG_W-1:0]   sel_tag  [1:2*N-1];
  logic               free_hit [1:2*N-1];
  logic [IDX_W-1:0]   free_idx [1:2*N-1];

  logic               issue_valid;
  logic [IDX_W-1:0]   issue_idx;
  logic [IDX_W-1:0]   wr_idx;

  // equal top bits compare directly, otherwise the larger low bits belong to the older tag
  function automatic logic older(input logic [TAG_W-1:0] a, input logic [TAG_W-1:0] b);
    if (a[TAG_W-1] == b[TAG_W-1]) begin
      return a <= b;
    end
    return a[TAG_W-2:0] > b[TAG_W-2:0];
  endfunction

  always_comb begin
    for (int k = 0; k < N; k++) begin
      sel_rdy[N+k]  = slot_valid[k] && slots[k].op1_valid && slots[k].op2_valid;
      sel_idx[N+k]  = IDX_W'(k);
      sel_tag[N+k]  = slot_tag[k];
      free_hit[N+k] = !slot_valid[k];
      free_idx[N+k] = IDX_W'(k);
    end
    for (int i = N - 1; i >= 1; i--) begin
      // oldest ready of the two children
      if (sel_rdy[2*i] && (!sel_rdy[2*i+1] || older(sel_tag[2*i], sel_tag[2*i+1]))) begin
        sel_idx[i] = sel_idx[2*i];
        sel_tag[i] = sel_tag[2*i];
      end else begin
        sel_idx[i] = sel_idx[2*i+1];
        sel_tag[i] = sel_tag[2*i+1];
      end
      sel_rdy[i] = sel_rdy[2*i] || sel_rdy[2*i+1];

      // any free slot, lower index first
      free_hit[i] = free_hit[2*i] || free_hit[2*i+1];
      free_idx[i] = free_hit[2*i] ? free_idx[2*i] : free_idx[2*i+1];
    end
  end

  assign issue_valid = sel_rdy[1];
  assign issue_idx   = sel_idx[1];
  assign wr_idx      = free_idx[1];
  assign full        = !free_hit[1];

  always_comb begin
    issue_op.alu_cmd = slots[issue_idx].alu_cmd;
    issue_op.op1     = slots[issue_idx].op1_data;
    issue_op.op2     = slots[issue_idx].op2_data;
    issue_op.phys_rd = slots[issue_idx].phys_rd;
    lane_valid = '0;
    if (issue_valid) begin
      lane_valid[rr_lane] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_valid <= '0;
      tag_ctr    <= '0;
      rr_lane    <= '0;
    end else begin
      if (issue_valid) begin
        slot_valid[issue_idx] <= 1'b0;
        rr_lane <= (rr_lane == LANE_W'(LANES - 1)) ? '0 : rr_lane + 1'b1;
      end
      if (entry_write) begin
        slot_valid[wr_idx] <= 1'b1;
        tag_ctr            <= tag_ctr + 1'b1;
      end
    end
  end

  // wakeup from the writeback banks, then the new entry
  always_ff @(posedge clk) begin
    for (int k = 0; k < N; k++) begin
      for (int b = 0; b < LANES; b++) begin
        if (slot_valid[k] && wb_bus[b].valid) begin
          if (!slots[k].op1_valid &&
              slots[k].op1_data[`OOO_PREG_W-1:0] == wb_bus[b].phys_rd) begin
            slots[k].op1_valid <= 1'b1;
            slots[k].op1_data  <= wb_bus[b].data;
          end
          if (!slots[k].op2_valid &&
              slots[k].op2_data[`OOO_PREG_W-1:0] == wb_bus[b].phys_rd) begin
            slots[k].op2_valid <= 1'b1;
            slots[k].op2_data  <= wb_bus[b].data;
          end
        end
      end
    end
    if (entry_write) begin
      slots[wr_idx]    <= entry;
      slot_tag[wr_idx] <= tag_ctr;
    end
  end

endmodule

/* verilog/alu_lane.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module alu_lane (
  input  logic               clk,
  input  logic               rst,
  input  logic               op_valid,
  input  ooo_pkg::exec_op_t  op,
  output ooo_pkg::wb_bank_t  result
);

  localparam int SH_W = $clog2(`OOO_XLEN);

  logic                   s1_valid;
  ooo_pkg::exec_op_t      s1_op;
  logic [`OOO_XLEN-1:0]   alu_out;
  logic                   res_valid;
  logic [`OOO_PREG_W-1:0] res_rd;
  logic [`OOO_XLEN-1:0]   res_data;

  // stage 1
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= op_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_op <= op;
  end

  always_comb begin
    unique case (s1_op.alu_cmd)
      ooo_pkg::ALU_ADD: alu_out = s1_op.op1 + s1_op.op2;
      ooo_pkg::ALU_SUB: alu_out = s1_op.op1 - s1_op.op2;
      ooo_pkg::ALU_AND: alu_out = s1_op.op1 & s1_op.op2;
      ooo_pkg::ALU_OR:  alu_out = s1_op.op1 | s1_op.op2;
      ooo_pkg::ALU_XOR: alu_out = s1_op.op1 ^ s1_op.op2;
      ooo_pkg::ALU_SLL: alu_out = s1_op.op1 << s1_op.op2[SH_W-1:0];
      ooo_pkg::ALU_SRL: alu_out = s1_op.op1 >> s1_op.op2[SH_W-1:0];
      // signed compare
      ooo_pkg::ALU_SLT: alu_out = `OOO_XLEN'($signed(s1_op.op1) < $signed(s1_op.op2));
    endcase
  end

  // stage 2
  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    res_rd   <= s1_op.phys_rd;
    res_data <= alu_out;
  end

  assign result = '{valid: res_valid, phys_rd: res_rd, data: res_data};

endmodule

/* verilog/wb_collector.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module wb_collector (
  input  logic              clk,
  input  logic              rst,
  input  ooo_pkg::wb_bus_t  lane_results,
  output ooo_pkg::wb_bus_t  wb_bus
);

  localparam int LANES = `OOO_NUM_LANES;

  logic [LANES-1:0]       bank_valid;
  logic [`OOO_PREG_W-1:0] bank_rd   [LANES];
  logic [`OOO_XLEN-1:0]   bank_data [LANES];

  // all banks move together so consumers see one aligned bus
  always_ff @(posedge clk) begin
    if (rst) begin
      bank_valid <= '0;
    end else begin
      for (int b = 0; b < LANES; b++) begin
        bank_valid[b] <= lane_results[b].valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < LANES; b++) begin
      bank_rd[b]   <= lane_results[b].phys_rd;
      bank_data[b] <= lane_results[b].data;
    end
  end

  always_comb begin
    for (int b = 0; b < LANES; b++) begin
      wb_bus[b].valid   = bank_valid[b];
      wb_bus[b].phys_rd = bank_rd[b];
      wb_bus[b].data    = bank_data[b];
    end
  end

endmodule

/* verilog/ooo_exec_core.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_exec_core (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    dispatch_valid,
  input  ooo_pkg::dispatch_req_t  dispatch_req,
  output logic                    full,
  output ooo_pkg::wb_bus_t        wb_bus
);

  logic [`OOO_PREG_W-1:0]    rd_addr_a;
  logic [`OOO_PREG_W-1:0]    rd_addr_b;
  logic [`OOO_XLEN-1:0]      rd_data_a;
  logic [`OOO_XLEN-1:0]      rd_data_b;
  logic                      rd_ready_a;
  logic                      rd_ready_b;
  logic                      alloc_valid;
  logic [`OOO_PREG_W-1:0]    alloc_rd;
  ooo_pkg::iq_entry_t        entry;
  logic                      entry_write;
  logic [`OOO_NUM_LANES-1:0] lane_valid;
  ooo_pkg::exec_op_t         issue_op;
  ooo_pkg::wb_bus_t          lane_results;

  phys_regfile u_regfile (
    .clk, .rst,
    .rd_addr_a, .rd_addr_b,
    .rd_data_a, .rd_data_b,
    .rd_ready_a, .rd_ready_b,
    .alloc_valid, .alloc_rd,
    .wb_bus
  );

  dispatch_unit u_dispatch (
    .dispatch_valid, .dispatch_req, .full,
    .rd_addr_a, .rd_addr_b,
    .rd_data_a, .rd_data_b,
    .rd_ready_a, .rd_ready_b,
    .wb_bus,
    .entry, .entry_write,
    .alloc_valid, .alloc_rd
  );

  issue_queue u_iq (
    .clk, .rst,
    .entry_write, .entry, .full,
    .wb_bus,
    .lane_valid, .issue_op
  );

  // one lane per writeback bank
  for (genvar g = 0; g < `OOO_NUM_LANES; g++) begin : g_lane
    alu_lane u_lane (
      .clk, .rst,
      .op_valid (lane_valid[g]),
      .op       (issue_op),
      .result   (lane_results[g])
    );
  end

  wb_collector u_wb (
    .clk, .rst,
    .lane_results,
    .wb_bus
  );

endmodule

/* testbench/ooo_exec_props.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_exec_props (
  input logic                       clk,
  input logic                       rst,
  input logic                       dispatch_valid,
  input logic                       full,
  input logic [`OOO_NUM_LANES-1:0]  lane_valid,
  input ooo_pkg::wb_bus_t           wb_bus
);

  logic bank_clash;

  // two valid banks aimed at one register
  always_comb begin
    bank_clash = 1'b0;
    for (int a = 0; a < `OOO_NUM_LANES; a++) begin
      for (int b = a + 1; b < `OOO_NUM_LANES; b++) begin
        if (wb_bus[a].valid && wb_bus[b].valid && wb_bus[a].phys_rd == wb_bus[b].phys_rd) begin
          bank_clash = 1'b1;
        end
      end
    end
  end

  no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
    !(dispatch_valid && full))
    else $error("dispatch_valid high while the issue queue is full");

  single_lane_issue: assert property (@(posedge clk) disable iff (rst) $onehot0(lane_valid))
    else $error("more than one lane_valid bit high");

  unique_wb_dest: assert property (@(posedge clk) disable iff (rst) !bank_clash)
    else $error("two writeback banks carry the same phys_rd");

endmodule

/* testbench/ooo_exec_tb.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_exec_tb;

  localparam int CLK_PERIOD  = 4;
  localparam int NUM_TESTS   = 5;
  localparam int PER_TEST    = `OOO_PHYS_REGS - 1;
  localparam int DRAIN_LIMIT = 100;
  localparam int CONSUMERS   = 6;
  localparam int LEAD_FILL   = 4;

  typedef logic [`OOO_PREG_W-1:0] preg_t;
  typedef logic [`OOO_XLEN-1:0]   word_t;

  logic                   clk;
  logic                   rst;
  logic                   dispatch_valid;
  ooo_pkg::dispatch_req_t dispatch_req;
  logic                   full;
  ooo_pkg::wb_bus_t       wb_bus;

  // reference model state, indexed by physical register
  word_t model_val  [`OOO_PHYS_REGS];
  preg_t model_src1 [`OOO_PHYS_REGS];
  preg_t model_src2 [`OOO_PHYS_REGS];
  logic  model_imm  [`OOO_PHYS_REGS];
  logic  done       [`OOO_PHYS_REGS];
  int    done_seq   [`OOO_PHYS_REGS];

  int    next_rd;
  int    done_count;
  int    wb_seq;
  int    check_count;
  int    error_count;
  int    errors_before;
  logic  saw_full;
  word_t rng;

  ooo_exec_core u_dut (
    .clk, .rst,
    .dispatch_valid, .dispatch_req,
    .full, .wb_bus
  );

  bind ooo_exec_core ooo_exec_props u_props (
    .clk, .rst, .dispatch_valid, .full, .lane_valid, .wb_bus
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // expected ALU result, shifts use the low 5 bits, slt is signed
  function automatic word_t alu_ref(input ooo_pkg::alu_cmd_t cmd, input word_t a, input word_t b);
    case (cmd)
      ooo_pkg::ALU_ADD: return a + b;
      ooo_pkg::ALU_SUB: return a - b;
      ooo_pkg::ALU_AND: return a & b;
      ooo_pkg::ALU_OR:  return a | b;
      ooo_pkg::ALU_XOR: return a ^ b;
      ooo_pkg::ALU_SLL: return a << b[4:0];
      ooo_pkg::ALU_SRL: return a >> b[4:0];
      default:          return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
    endcase
  endfunction

  task automatic check_value(input string what, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Fail at %0d ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("Error at %0d ns: %s", $time, msg);
  endtask

  task automatic apply_reset();
    rst            = 1'b1;
    dispatch_valid = 1'b0;
    repeat (2) @(negedge clk);
    for (int r = 0; r < `OOO_PHYS_REGS; r++) begin
      model_val[r] = '0;
      done[r]      = 1'b0;
      done_seq[r]  = 0;
    end
    next_rd    = 1;
    done_count = 0;
    saw_full   = 1'b0;
    rst        = 1'b0;
    @(negedge clk);
    check_value("full after reset", word_t'(full), '0);
    for (int b = 0; b < `OOO_NUM_LANES; b++) begin
      check_value($sformatf("wb bank %0d valid after reset", b), word_t'(wb_bus[b].valid), '0);
    end
  endtask

  // model first, then hold off while the queue is full
  task automatic dispatch_instr(input ooo_pkg::alu_cmd_t cmd, input preg_t src1, input preg_t src2,
                                input logic use_imm, input word_t imm);
    word_t b;
    b = use_imm ? imm : model_val[src2];
    model_val[next_rd]  = alu_ref(cmd, model_val[src1], b);
    model_src1[next_rd] = src1;
    model_src2[next_rd] = src2;
    model_imm[next_rd]  = use_imm;
    while (full) begin
      saw_full = 1'b1;
      @(negedge clk);
    end
    dispatch_req = '{alu_cmd: cmd, src1: src1, src2: src2, use_imm: use_imm, imm: imm,
                     phys_rd: preg_t'(next_rd)};
    dispatch_valid = 1'b1;
    @(negedge clk);
    dispatch_valid = 1'b0;
    next_rd++;
  endtask

  task automatic record_writeback(input preg_t rd, input word_t data);
    int r;
    r = int'(rd);
    if (r == 0 || r >= next_rd) begin
      report_error($sformatf("writeback to r%0d, which was never dispatched", r));
      return;
    end
    if (done[r]) begin
      report_error($sformatf("register r%0d completed twice", r));
      return;
    end
    if (model_src1[r] != '0 && !done[model_src1[r]]) begin
      report_error($sformatf("r%0d written back before its source r%0d", r, model_src1[r]));
    end
    if (!model_imm[r] && model_src2[r] != '0 && !done[model_src2[r]]) begin
      report_error($sformatf("r%0d written back before its source r%0d", r, model_src2[r]));
    end
    check_value($sformatf("result of r%0d", r), data, model_val[r]);
    done[r]     = 1'b1;
    done_seq[r] = wb_seq;
    wb_seq++;
    done_count++;
  endtask

  // outputs only change at posedge, so the falling edge sees them settled
  always @(negedge clk) begin
    if (!rst) begin
      if (!$onehot0(u_dut.lane_valid)) begin
        report_error("more than one lane issued in one cycle");
      end
      for (int b = 0; b < `OOO_NUM_LANES; b++) begin
        if (wb_bus[b].valid) begin
          record_writeback(wb_bus[b].phys_rd, wb_bus[b].data);
        end
      end
    end
  end

  task automatic drain_results();
    int waited;
    waited = 0;
    while (done_count < PER_TEST && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    // a few more cycles to catch stray or repeated results
    repeat (4) @(negedge clk);
    for (int r = 1; r <= PER_TEST; r++) begin
      if (!done[r]) begin
        report_error($sformatf("register r%0d never completed", r));
      end
    end
  endtask

  task automatic test_imm_only();
    word_t r;
    repeat (PER_TEST) begin
      r = next_rand();
      dispatch_instr(ooo_pkg::alu_cmd_t'(r[2:0]), '0, '0, 1'b1, next_rand());
    end
    drain_results();
  endtask

  task automatic test_random_deps();
    word_t r;
    preg_t s1;
    preg_t s2;
    repeat (PER_TEST) begin
      r  = next_rand();
      s1 = preg_t'(r[15:8] % next_rd);
      s2 = preg_t'(r[23:16] % next_rd);
      dispatch_instr(ooo_pkg::alu_cmd_t'(r[2:0]), s1, s2, r[3], next_rand());
    end
    drain_results();
  endtask

  task automatic test_serial_chain();
    word_t r;
    dispatch_instr(ooo_pkg::ALU_ADD, '0, '0, 1'b1, next_rand());
    repeat (PER_TEST - 1) begin
      r = next_rand();
      dispatch_instr(ooo_pkg::alu_cmd_t'(r[2:0]), preg_t'(next_rd - 1), preg_t'(next_rd - 1),
                     r[3], next_rand());
    end
    drain_results();
    if (!saw_full) begin
      report_error("issue queue never reported full during the serial chain");
    end
  endtask

  // independent lead-in, one producer, its consumers, then independent fill
  // the lead-in places the consumer tags across the step from 7 to 8
  task automatic test_oldest_first();
    word_t r;
    preg_t prod;
    repeat (LEAD_FILL) begin
      dispatch_instr(ooo_pkg::ALU_ADD, '0, '0, 1'b1, next_rand());
    end
    prod = preg_t'(next_rd);
    dispatch_instr(ooo_pkg::ALU_ADD, '0, '0, 1'b1, next_rand());
    repeat (CONSUMERS) begin
      r = next_rand();
      dispatch_instr(ooo_pkg::alu_cmd_t'(r[2:0]), prod, r[4] ? prod : preg_t'(0),
                     r[3], next_rand());
    end
    while (next_rd <= PER_TEST) begin
      r = next_rand();
      dispatch_instr(ooo_pkg::alu_cmd_t'(r[2:0]), '0, '0, 1'b1, next_rand());
    end
    drain_results();
    for (int k = int'(prod) + 2; k <= int'(prod) + CONSUMERS; k++) begin
      if (done[k] && done[k-1] && done_seq[k] < done_seq[k-1]) begin
        report_error($sformatf("consumer r%0d completed before older consumer r%0d", k, k - 1));
      end
    end
  endtask

  task automatic test_zero_reg();
    repeat (PER_TEST) begin
      dispatch_instr(ooo_pkg::ALU_ADD, '0, '0, 1'b1, next_rand());
    end
    drain_results();
  endtask

  initial begin
    rng            = 32'hda0f;
    rst            = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_req   = '0;
    next_rd        = 1;
    done_count     = 0;
    wb_seq         = 0;
    check_count    = 0;
    error_count    = 0;
    saw_full       = 1'b0;
    for (int t = 1; t <= NUM_TESTS; t++) begin
      errors_before = error_count;
      apply_reset();
      case (t)
        1: test_imm_only();
        2: test_random_deps();
        3: test_serial_chain();
        4: test_oldest_first();
        default: test_zero_reg();
      endcase
      $display("test %0d finished with %0d errors", t, error_count - errors_before);
    end
    $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // limit is tests x instructions x 8 cycles
  initial begin
    repeat (NUM_TESTS * PER_TEST * 8) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+verilog
verilog/ooo_pkg.sv
verilog/phys_regfile.sv
verilog/dispatch_unit.sv
verilog/issue_queue.sv
verilog/alu_lane.sv
verilog/wb_collector.sv
verilog/ooo_exec_core.sv
testbench/ooo_exec_props.sv
testbench/ooo_exec_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= ooo_exec_tb
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
	  --Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); status=$$?; \
	echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qx 'TESTS PASSED'; then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
